// File: common/qu_uop_pkg.sv
// Micro-op encoding for the integer execute path
// Only the ALU path exists, so there is no optype field
// Opcode values 12..15 are unused and decode as an unsigned compare
// Shift amounts are SHAMT_W bits, which assumes a 32-bit datapath

`default_nettype none

package qu_uop_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int ALU_OP_W = 4;
    localparam int SHAMT_W  = 5;     // Low bits of opd2 used by shifts

    // ======================================================================
    // Opcodes and operand source
    // ======================================================================
    typedef enum logic [ALU_OP_W-1:0]
    {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SRA = 4'd7,
        EQ  = 4'd8,
        NE  = 4'd9,
        LT  = 4'd10,     // Signed
        LTU = 4'd11
    } alu_op_e;

    typedef enum logic
    {
        ALU_INPUT_SEL_R_I  = 1'b0,   // Register or immediate operands
        ALU_INPUT_SEL_NONE = 1'b1    // Both operands forced to zero
    } alu_input_sel_e;

    typedef struct packed
    {
        alu_op_e        alu_op;
        alu_input_sel_e alu_input_sel;
        logic           rs1_valid;
        logic           rs2_valid;
        logic           imm_valid;   // Only looked at when rs2_valid is low
    } uop_t;

endpackage

`default_nettype wire

// File: common/qu_common_pkg.sv
// Storage and tagging types for the reservation station and execute stage
// Tags are producer names; a tag must not be reused while it is in flight
// Values in an entry are only meaningful once the matching ready flag is set

`default_nettype none

package qu_common_pkg;
    import qu_uop_pkg::*;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int XLEN     = 32;
    localparam int TAG_W    = 4;                    // 16 tags in flight
    localparam int RS_DEPTH = 4;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    typedef logic [TAG_W-1:0] tag_t;

    // ======================================================================
    // Reservation station entry
    // ======================================================================
    typedef struct packed
    {
        uop_t            op;
        tag_t            tag;        // Destination tag, goes out on the CDB
        logic [XLEN-1:0] vj;
        logic [XLEN-1:0] vk;
        tag_t            qj;         // Producer of vj while not ready
        tag_t            qk;
        logic            qj_ready;
        logic            qk_ready;
        logic [XLEN-1:0] a;          // Immediate
    } res_st_cell_t;

endpackage

`default_nettype wire

// File: common/dispatch_if.sv
// Dispatch channel into the reservation station
// A micro-op is taken on a rising edge with valid high and full low
// There is no handshake beyond full; the source must hold off while it is high

`default_nettype none

interface dispatch_if
    import qu_uop_pkg::*;
    import qu_common_pkg::*;
();
    logic            valid;
    tag_t            tag;
    uop_t            uop;
    logic            rs1_ready;
    tag_t            rs1_tag;
    logic [XLEN-1:0] rs1_value;
    logic            rs2_ready;
    tag_t            rs2_tag;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] imm;
    logic            full;

    modport source (output valid, tag, uop, rs1_ready, rs1_tag, rs1_value,
                    rs2_ready, rs2_tag, rs2_value, imm, input full);

    modport sink   (input valid, tag, uop, rs1_ready, rs1_tag, rs1_value,
                    rs2_ready, rs2_tag, rs2_value, imm, output full);

endinterface

`default_nettype wire

// File: common/cdb_if.sv
// Common data bus, one completed micro-op per valid cycle
// valid is a single-cycle pulse and the bus never stalls
// Listeners must capture in the same cycle or lose the value

`default_nettype none

interface cdb_if
    import qu_common_pkg::*;
();
    logic            valid;
    tag_t            tag;
    logic [XLEN-1:0] value;
    logic            comp;   // Compare flag, low for non-compare ops

    modport driver   (output valid, tag, value, comp);
    modport listener (input valid, tag, value, comp);

endinterface

`default_nettype wire

// File: rtl/alu/alu.sv
// Integer ALU, purely combinational
// Compare ops return their flag zero-extended on alu_result
// Shifts take the low SHAMT_W bits of opd2, so XLEN is expected to be 32

`default_nettype none

module alu
    import qu_uop_pkg::*;
#(
    parameter int XLEN = 32
)(
    input  logic [XLEN-1:0] opd1,
    input  logic [XLEN-1:0] opd2,
    input  alu_op_e         alu_op,
    output logic [XLEN-1:0] alu_result,
    output logic            comp_result
);

    typedef enum logic [1:0]
    {
        SUB_ARITH,
        SUB_LOGIC,
        SUB_SHIFT,
        SUB_COMP
    } subunit_e;

    subunit_e           subunit_sel;
    logic               sub_en;
    logic [XLEN-1:0]    arith_res;
    logic [XLEN-1:0]    logic_res;
    logic [XLEN-1:0]    shift_res;
    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               comp_res;

    // ======================================================================
    // Opcode decode
    // ======================================================================
    always_comb
    begin
        case (alu_op)
            ADD, SUB:      subunit_sel = SUB_ARITH;
            AND, OR, XOR:  subunit_sel = SUB_LOGIC;
            SLL, SRL, SRA: subunit_sel = SUB_SHIFT;
            default:       subunit_sel = SUB_COMP;
        endcase
    end

    assign sub_en = (alu_op == SUB);

    // Adder, subtract as a + ~b + 1
    assign arith_res = opd1 + (sub_en ? ~opd2 : opd2) + XLEN'(sub_en);

    always_comb
    begin
        case (alu_op)
            AND:     logic_res = opd1 & opd2;
            OR:      logic_res = opd1 | opd2;
            default: logic_res = opd1 ^ opd2;
        endcase
    end

    assign shamt = opd2[SHAMT_W-1:0];

    always_comb
    begin
        case (alu_op)
            SLL:     shift_res = opd1 << shamt;
            SRL:     shift_res = opd1 >> shamt;
            default: shift_res = $signed(opd1) >>> shamt;   // SRA
        endcase
    end

    // Comparator
    assign eq   = (opd1 == opd2);
    assign lt_s = ($signed(opd1) < $signed(opd2));
    assign lt_u = (opd1 < opd2);

    always_comb
    begin
        case (alu_op)
            EQ:      comp_res = eq;
            NE:      comp_res = !eq;
            LT:      comp_res = lt_s;
            default: comp_res = lt_u;
        endcase
    end

    // ======================================================================
    // Result select
    // ======================================================================
    always_comb
    begin
        comp_result = 1'b0;
        case (subunit_sel)
            SUB_ARITH: alu_result = arith_res;
            SUB_LOGIC: alu_result = logic_res;
            SUB_SHIFT: alu_result = shift_res;
            default:
            begin
                comp_result = comp_res;
                alu_result  = {{(XLEN-1){1'b0}}, comp_res};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/execute.sv
// Execute stage, combinational from the issue register to the CDB
// Only the ALU path exists; the CDB pulse follows issue_valid directly
// Operand sources follow the micro-op's valid bits, vk before the immediate

`default_nettype none

module execute
    import qu_uop_pkg::*;
    import qu_common_pkg::*;
(
    input  res_st_cell_t op_in,
    input  logic         issue_valid,
    cdb_if.driver        cdb
);

    logic [XLEN-1:0] alu_opd1;
    logic [XLEN-1:0] alu_opd2;
    logic [XLEN-1:0] alu_result_out;
    logic            alu_comp_out;

    // Operand select
    always_comb
    begin
        case (op_in.op.alu_input_sel)
            ALU_INPUT_SEL_R_I:
            begin
                alu_opd1 = op_in.op.rs1_valid ? op_in.vj : '0;

                alu_opd2 = op_in.op.rs2_valid ? op_in.vk
                         : op_in.op.imm_valid ? op_in.a
                         : '0;
            end
            default:    // ALU_INPUT_SEL_NONE
            begin
                alu_opd1 = '0;
                alu_opd2 = '0;
            end
        endcase
    end

    alu #(
        .XLEN(XLEN)
    ) qu_alu (
        .opd1        (alu_opd1),
        .opd2        (alu_opd2),
        .alu_op      (op_in.op.alu_op),
        .alu_result  (alu_result_out),
        .comp_result (alu_comp_out)
    );

    // Broadcast
    assign cdb.valid = issue_valid;
    assign cdb.tag   = op_in.tag;
    assign cdb.value = alu_result_out;
    assign cdb.comp  = alu_comp_out;

endmodule

`default_nettype wire

// File: rtl/res_station/res_station.sv
// Reservation station with RS_DEPTH entries and a registered issue slot
// Fills the lowest free entry and issues the lowest ready one each cycle
// Operands wake up from the CDB at the capturing edge, so a woken entry
// issues one cycle later. A dispatch while full is dropped.

`default_nettype none

module res_station
    import qu_common_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    dispatch_if.sink     disp,
    cdb_if.listener      cdb,
    output logic         issue_valid,
    output res_st_cell_t issue_cell
);

    res_st_cell_t            entries [RS_DEPTH];
    logic [RS_DEPTH-1:0]     occupied;
    logic [RS_DEPTH-1:0]     occupied_nxt;
    logic [RS_DEPTH-1:0]     ready_vec;
    logic [RS_IDX_W-1:0]     free_idx;
    logic [RS_IDX_W-1:0]     issue_idx;
    logic                    has_free;
    logic                    has_ready;
    logic                    disp_fire;
    res_st_cell_t            new_cell;
    logic [(1 << TAG_W)-1:0] tag_live;   // Accepted and not yet on the CDB

    function automatic logic cdb_match(input tag_t t);
        return cdb.valid && (cdb.tag == t);
    endfunction

    // ======================================================================
    // Entry selection
    // ======================================================================
    always_comb
    begin
        free_idx  = '0;
        has_free  = 1'b0;
        issue_idx = '0;
        has_ready = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)     // Lowest index wins
        begin
            ready_vec[i] = occupied[i] && entries[i].qj_ready && entries[i].qk_ready;
            if (!occupied[i])
            begin
                free_idx = RS_IDX_W'(i);
                has_free = 1'b1;
            end
            if (ready_vec[i])
            begin
                issue_idx = RS_IDX_W'(i);
                has_ready = 1'b1;
            end
        end
    end

    assign disp.full = !has_free;
    assign disp_fire = disp.valid && has_free;

    // New entry, with CDB bypass for a producer finishing this cycle
    always_comb
    begin
        new_cell.op       = disp.uop;
        new_cell.tag      = disp.tag;
        new_cell.qj       = disp.rs1_tag;
        new_cell.qk       = disp.rs2_tag;
        new_cell.a        = disp.imm;
        new_cell.qj_ready = disp.rs1_ready || cdb_match(disp.rs1_tag);
        new_cell.qk_ready = disp.rs2_ready || cdb_match(disp.rs2_tag);
        new_cell.vj       = disp.rs1_ready ? disp.rs1_value : cdb.value;
        new_cell.vk       = disp.rs2_ready ? disp.rs2_value : cdb.value;
    end

    always_comb
    begin
        occupied_nxt = occupied;
        if (disp_fire)
            occupied_nxt[free_idx] = 1'b1;
        if (has_ready)
            occupied_nxt[issue_idx] = 1'b0;   // Never the same entry as free_idx
    end

    // ======================================================================
    // State
    // ======================================================================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            occupied    <= '0;
            issue_valid <= 1'b0;
        end
        else
        begin
            occupied    <= occupied_nxt;
            issue_valid <= has_ready;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            if (occupied[i] && !entries[i].qj_ready && cdb_match(entries[i].qj))
            begin
                entries[i].vj       <= cdb.value;
                entries[i].qj_ready <= 1'b1;
            end
            if (occupied[i] && !entries[i].qk_ready && cdb_match(entries[i].qk))
            begin
                entries[i].vk       <= cdb.value;
                entries[i].qk_ready <= 1'b1;
            end
        end
        if (disp_fire)
            entries[free_idx] <= new_cell;
        if (has_ready)
            issue_cell <= entries[issue_idx];
    end

    // Tags owned by an occupied or issued entry
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            tag_live <= '0;
        else
        begin
            if (cdb.valid)
                tag_live[cdb.tag] <= 1'b0;
            if (disp_fire)
                tag_live[disp.tag] <= 1'b1;
        end
    end

    // ======================================================================
    // Assertions
    // ======================================================================
    a_no_disp_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) disp.valid |-> !disp.full)
        else $error("dispatch while reservation station full, micro-op dropped");

    a_issue_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> (issue_cell.qj_ready && issue_cell.qk_ready))
        else $error("issued entry has an operand not ready");

    a_cdb_tag_owned: assert property (
        @(posedge clk) disable iff (!rst_n) cdb.valid |-> tag_live[cdb.tag])
        else $error("CDB tag %0d has no owner", cdb.tag);

endmodule

`default_nettype wire

// File: rtl/qu_exec_top.sv
// Top of the integer execute path
// Dispatch comes in on plain ports and is accepted when rs_full is low
// Results leave as a one-cycle cdb_valid pulse with tag, value and flag

`default_nettype none

module qu_exec_top
    import qu_uop_pkg::*;
    import qu_common_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            disp_valid,
    input  tag_t            disp_tag,
    input  alu_op_e         disp_alu_op,
    input  alu_input_sel_e  disp_input_sel,
    input  logic            disp_rs1_valid,
    input  logic            disp_rs2_valid,
    input  logic            disp_imm_valid,
    input  logic            disp_rs1_ready,
    input  tag_t            disp_rs1_tag,
    input  logic [XLEN-1:0] disp_rs1_value,
    input  logic            disp_rs2_ready,
    input  tag_t            disp_rs2_tag,
    input  logic [XLEN-1:0] disp_rs2_value,
    input  logic [XLEN-1:0] disp_imm,
    output logic            rs_full,

    output logic            cdb_valid,
    output tag_t            cdb_tag,
    output logic [XLEN-1:0] cdb_value,
    output logic            cdb_comp
);

    dispatch_if disp ();
    cdb_if      cdb ();

    logic         issue_valid;
    res_st_cell_t issue_cell;

    // Dispatch ports into the interface
    assign disp.valid     = disp_valid;
    assign disp.tag       = disp_tag;
    assign disp.uop       = '{alu_op:        disp_alu_op,
                              alu_input_sel: disp_input_sel,
                              rs1_valid:     disp_rs1_valid,
                              rs2_valid:     disp_rs2_valid,
                              imm_valid:     disp_imm_valid};
    assign disp.rs1_ready = disp_rs1_ready;
    assign disp.rs1_tag   = disp_rs1_tag;
    assign disp.rs1_value = disp_rs1_value;
    assign disp.rs2_ready = disp_rs2_ready;
    assign disp.rs2_tag   = disp_rs2_tag;
    assign disp.rs2_value = disp_rs2_value;
    assign disp.imm       = disp_imm;
    assign rs_full        = disp.full;

    res_station u_res_station (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp        (disp.sink),
        .cdb         (cdb.listener),
        .issue_valid (issue_valid),
        .issue_cell  (issue_cell)
    );

    execute u_execute (
        .op_in       (issue_cell),
        .issue_valid (issue_valid),
        .cdb         (cdb.driver)
    );

    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_value = cdb.value;
    assign cdb_comp  = cdb.comp;

endmodule

`default_nettype wire

// File: verif/exec_model.svh
// Reference model for the execute path, included inside the testbench module
// Expected values are computed at dispatch time, so a consumer reads its
// producer's result before the producer reaches the CDB
// Assumes XLEN of 32, since shifts use the low 5 bits of the second operand

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

localparam int NUM_TAGS = 1 << TAG_W;

logic            in_flight [NUM_TAGS];   // Dispatched, not yet seen on the CDB
logic [XLEN-1:0] exp_value [NUM_TAGS];
logic            exp_comp  [NUM_TAGS];

// vmask is {rs1_valid, rs2_valid, imm_valid}
function automatic logic [XLEN-1:0] model_result(
    input alu_op_e op, input alu_input_sel_e sel, input logic [2:0] vmask,
    input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2,
    input logic [XLEN-1:0] imm, output logic flag);
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;

    x    = '0;
    y    = '0;
    flag = 1'b0;
    if (sel == ALU_INPUT_SEL_R_I)
    begin
        x = vmask[2] ? v1 : '0;
        y = vmask[1] ? v2 : (vmask[0] ? imm : '0);   // vk before the immediate
    end
    case (op)
        ADD:     return x + y;
        SUB:     return x - y;
        AND:     return x & y;
        OR:      return x | y;
        XOR:     return x ^ y;
        SLL:     return x << y[4:0];
        SRL:     return x >> y[4:0];
        SRA:     return $signed(x) >>> y[4:0];
        EQ:      flag = (x == y);
        NE:      flag = (x != y);
        LT:      flag = ($signed(x) < $signed(y));
        default: flag = (x < y);
    endcase
    return {{(XLEN-1){1'b0}}, flag};
endfunction

// First free tag at or after start, wrapping
function automatic tag_t alloc_tag(input int start);
    tag_t t;

    for (int i = 0; i < NUM_TAGS; i++)
    begin
        t = tag_t'(start + i);
        if (!in_flight[t])
            return t;
    end
    return tag_t'(start);
endfunction

function automatic logic pick_in_flight(input int start, output tag_t t);
    t = tag_t'(start);
    for (int i = 0; i < NUM_TAGS; i++)
    begin
        t = tag_t'(start + i);
        if (in_flight[t])
            return 1'b1;
    end
    return 1'b0;
endfunction

function automatic int count_in_flight();
    int n;

    n = 0;
    for (int i = 0; i < NUM_TAGS; i++)
    begin
        if (in_flight[tag_t'(i)])
            n++;
    end
    return n;
endfunction

`endif

// File: verif/tb_qu_exec.sv
// Self-checking testbench for the integer execute path
// Random micro-ops from a fixed seed are checked on the CDB against a model
// Dependent micro-ops name only tags that the model still holds in flight
// Dispatch is held off while rs_full is high, except in the one short burst

`default_nettype none

module tb_qu_exec
    import qu_uop_pkg::*;
    import qu_common_pkg::*;
();
    localparam int FULL_TIMEOUT  = 100;   // Cycles
    localparam int DRAIN_TIMEOUT = 300;

    logic            clk;
    logic            rst_n;
    logic            disp_valid;
    tag_t            disp_tag;
    alu_op_e         disp_alu_op;
    alu_input_sel_e  disp_input_sel;
    logic            disp_rs1_valid;
    logic            disp_rs2_valid;
    logic            disp_imm_valid;
    logic            disp_rs1_ready;
    tag_t            disp_rs1_tag;
    logic [XLEN-1:0] disp_rs1_value;
    logic            disp_rs2_ready;
    tag_t            disp_rs2_tag;
    logic [XLEN-1:0] disp_rs2_value;
    logic [XLEN-1:0] disp_imm;
    logic            rs_full;
    logic            cdb_valid;
    tag_t            cdb_tag;
    logic [XLEN-1:0] cdb_value;
    logic            cdb_comp;

    integer seed = 51351;
    int     err_count;
    int     check_count;
    int     test_num;
    int     test_err_base;
    int     tests_passed;
    int     tests_failed;
    int     dispatched;
    int     completed;
    int     bypass_seen;      // Consumers dispatched during their producer's CDB pulse
    tag_t   last_tag;

    `include "exec_model.svh"

    qu_exec_top u_qu_exec_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .disp_valid     (disp_valid),
        .disp_tag       (disp_tag),
        .disp_alu_op    (disp_alu_op),
        .disp_input_sel (disp_input_sel),
        .disp_rs1_valid (disp_rs1_valid),
        .disp_rs2_valid (disp_rs2_valid),
        .disp_imm_valid (disp_imm_valid),
        .disp_rs1_ready (disp_rs1_ready),
        .disp_rs1_tag   (disp_rs1_tag),
        .disp_rs1_value (disp_rs1_value),
        .disp_rs2_ready (disp_rs2_ready),
        .disp_rs2_tag   (disp_rs2_tag),
        .disp_rs2_value (disp_rs2_value),
        .disp_imm       (disp_imm),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_comp       (cdb_comp)
    );

    initial
        clk = 1'b0;
    always #4 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic int rnd_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // rs_full only changes at the rising edge, so look at it mid-cycle
    task automatic wait_not_full();
        int cycles;

        cycles = 0;
        @(negedge clk);
        while (rs_full !== 1'b0 && cycles < FULL_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rs_full !== 1'b0)
            abort_on_timeout("rs_full to drop");
    endtask

    task automatic wait_drained();
        int cycles;

        cycles = 0;
        while (count_in_flight() != 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (count_in_flight() != 0)
            abort_on_timeout("all dispatched tags to reach the CDB");
        else
            repeat (2) @(posedge clk);
    endtask

    task automatic end_dispatch();
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    // rs1 depends on last_tag when dep1_en; burst leaves valid high for the next call
    task automatic dispatch_uop(input alu_op_e op, input alu_input_sel_e sel,
                                input logic [2:0] vmask, input logic dep1_en,
                                input logic dep2_en, input tag_t dep2, input logic burst);
        tag_t            t;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] res;
        logic            r1;
        logic            r2;
        logic            flag;

        if (!burst)
            wait_not_full();
        @(posedge clk);
        a   = $random(seed);
        b   = (rnd_below(4) == 0) ? a : $random(seed);   // Equal operands now and then
        imm = $random(seed);
        r1  = 1'b1;
        r2  = 1'b1;
        if (dep1_en)
        begin
            a  = exp_value[last_tag];
            r1 = !in_flight[last_tag];    // Producer already done, pass its value
        end
        if (dep2_en)
        begin
            b  = exp_value[dep2];
            r2 = !in_flight[dep2];
        end
        res          = model_result(op, sel, vmask, a, b, imm, flag);
        t            = alloc_tag(rnd_below(NUM_TAGS));
        in_flight[t] = 1'b1;
        exp_value[t] = res;
        exp_comp[t]  = flag;
        dispatched++;

        disp_valid     <= 1'b1;
        disp_tag       <= t;
        disp_alu_op    <= op;
        disp_input_sel <= sel;
        {disp_rs1_valid, disp_rs2_valid, disp_imm_valid} <= vmask;
        disp_rs1_ready <= r1;
        disp_rs1_tag   <= dep1_en ? last_tag : '0;
        disp_rs1_value <= a;
        disp_rs2_ready <= r2;
        disp_rs2_tag   <= dep2_en ? dep2 : '0;
        disp_rs2_value <= b;
        disp_imm       <= imm;
        last_tag = t;
        if (!burst)
            end_dispatch();
    endtask

    task automatic begin_test();
        test_num++;
        test_err_base = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_base)
        begin
            tests_passed++;
            $display("Test %0d %s: PASS", test_num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAIL, %0d errors", test_num, name,
                     err_count - test_err_base);
        end
    endtask

    // ======================================================================
    // CDB monitor
    // ======================================================================
    always @(negedge clk)
    begin
        if (rst_n === 1'b1 && cdb_valid === 1'b1)
        begin
            check_count++;
            assert (in_flight[cdb_tag] === 1'b1)
            else
            begin
                $display("FAILED at %0t: tag %0d on the CDB is not in flight", $time, cdb_tag);
                err_count++;
            end
            if (in_flight[cdb_tag] === 1'b1)
            begin
                assert (cdb_value === exp_value[cdb_tag] && cdb_comp === exp_comp[cdb_tag])
                else
                begin
                    $display("FAILED at %0t: tag %0d gave %h comp %b, expected %h comp %b",
                             $time, cdb_tag, cdb_value, cdb_comp,
                             exp_value[cdb_tag], exp_comp[cdb_tag]);
                    err_count++;
                end
                in_flight[cdb_tag] = 1'b0;
            end
            completed++;    // Every pulse, so a repeated tag shows in the count
            if (disp_valid && !disp_rs1_ready && disp_rs1_tag == cdb_tag)
                bypass_seen++;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial
    begin
        tag_t q;
        logic found;
        int   d0;
        int   c0;

        rst_n          = 1'b0;
        disp_valid     = 1'b0;
        disp_tag       = '0;
        disp_alu_op    = ADD;
        disp_input_sel = ALU_INPUT_SEL_R_I;
        disp_rs1_valid = 1'b0;
        disp_rs2_valid = 1'b0;
        disp_imm_valid = 1'b0;
        disp_rs1_ready = 1'b0;
        disp_rs1_tag   = '0;
        disp_rs1_value = '0;
        disp_rs2_ready = 1'b0;
        disp_rs2_tag   = '0;
        disp_rs2_value = '0;
        disp_imm       = '0;
        last_tag       = '0;
        for (int i = 0; i < NUM_TAGS; i++)
        begin
            in_flight[tag_t'(i)] = 1'b0;
            exp_value[tag_t'(i)] = '0;
            exp_comp[tag_t'(i)]  = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        repeat (5)
        begin
            @(negedge clk);
            check_count++;
            assert (cdb_valid === 1'b0 && rs_full === 1'b0)
            else
            begin
                $display("FAILED at %0t: cdb_valid=%b rs_full=%b while idle",
                         $time, cdb_valid, rs_full);
                err_count++;
            end
        end
        end_test("reset and idle");

        begin_test();
        for (int i = 0; i < 12; i++)
            repeat (3)
                dispatch_uop(alu_op_e'(4'(i)), ALU_INPUT_SEL_R_I, 3'b110,
                             1'b0, 1'b0, '0, 1'b0);
        wait_drained();
        end_test("independent ops");

        begin_test();
        repeat (40)
            dispatch_uop(alu_op_e'(4'(rnd_below(12))),
                         (rnd_below(4) == 0) ? ALU_INPUT_SEL_NONE : ALU_INPUT_SEL_R_I,
                         3'(rnd_below(8)), 1'b0, 1'b0, '0, 1'b0);
        wait_drained();
        end_test("operand select");

        begin_test();
        bypass_seen = 0;
        dispatch_uop(ADD, ALU_INPUT_SEL_R_I, 3'b110, 1'b0, 1'b0, '0, 1'b0);
        dispatch_uop(SUB, ALU_INPUT_SEL_R_I, 3'b110, 1'b1, 1'b0, '0, 1'b0);
        repeat (40)
        begin
            found = pick_in_flight(rnd_below(NUM_TAGS), q);
            dispatch_uop(alu_op_e'(4'(rnd_below(12))), ALU_INPUT_SEL_R_I, 3'b110,
                         rnd_below(2) == 1, found && rnd_below(2) == 1, q, 1'b0);
        end
        wait_drained();
        check_count++;
        assert (bypass_seen > 0)
        else
        begin
            $display("FAILED at %0t: no consumer met its producer's CDB pulse", $time);
            err_count++;
        end
        end_test("dependency chains");

        // A chain dispatched every cycle outruns its two-cycle links
        begin_test();
        d0 = dispatched;
        c0 = completed;
        dispatch_uop(alu_op_e'(4'(rnd_below(12))), ALU_INPUT_SEL_R_I, 3'b110,
                     1'b0, 1'b0, '0, 1'b1);
        repeat (6)
            dispatch_uop(alu_op_e'(4'(rnd_below(12))), ALU_INPUT_SEL_R_I, 3'b110,
                         1'b1, 1'b0, '0, 1'b1);
        end_dispatch();
        @(negedge clk);
        check_count++;
        assert (rs_full === 1'b1)
        else
        begin
            $display("FAILED at %0t: rs_full=%b with four waiting entries", $time, rs_full);
            err_count++;
        end
        repeat (6)
            dispatch_uop(alu_op_e'(4'(rnd_below(12))), ALU_INPUT_SEL_R_I, 3'b110,
                         rnd_below(2) == 1, 1'b0, '0, 1'b0);
        wait_drained();
        check_count++;
        assert (completed - c0 == dispatched - d0)
        else
        begin
            $display("FAILED at %0t: %0d dispatched but %0d completed", $time,
                     dispatched - d0, completed - c0);
            err_count++;
        end
        end_test("back-pressure");

        $display("Tests: %0d run, %0d passed, %0d failed; checks: %0d, errors: %0d",
                 test_num, tests_passed, tests_failed, check_count, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verif
common/qu_uop_pkg.sv
common/qu_common_pkg.sv
common/dispatch_if.sv
common/cdb_if.sv
rtl/alu/alu.sv
rtl/execute.sv
rtl/res_station/res_station.sv
rtl/qu_exec_top.sv
verif/tb_qu_exec.sv

// File: run_sim.sh
#!/bin/sh
# Builds the execute path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_qu_exec \
    -Mdir obj_dir -o sim_qu_exec
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_qu_exec)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in the output"
exit 1
